// File: src/lpRegsPkg.sv
// Bus word, register select, CSR bit positions and bus write struct for the LP20 registers

`default_nettype none

package lpRegsPkg;

   //////////////////////////////////////////////////
   // Bus types
   //////////////////////////////////////////////////

   // Host bus data word
   typedef logic [35:0] lpWord;

   // Register select on the host bus
   typedef logic [1:0] lpRegAddr;

   // Stored diagnostic byte
   typedef logic [7:0] lpCsrb;

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////

   localparam lpRegAddr addrCsra = 2'd0;
   localparam lpRegAddr addrCsrb = 2'd1;
   localparam lpRegAddr addrPctr = 2'd2;
   // Read only, writes are dropped
   localparam lpRegAddr addrLine = 2'd3;

   // CSRA bit positions
   // Init is a write-only pulse, reads back as zero
   localparam int csraInit      = 0;
   localparam int csraIntEnable = 1;
   // Page zero is sticky, write 1 to clear
   localparam int csraPageZero  = 2;
   localparam int csraTestPctr  = 3;

   // CSRB write bit that steps the page counter in test mode
   localparam int csrbTestStep  = 0;

   // Single-cycle host write
   typedef struct packed {
      logic     wr;
      lpRegAddr addr;
      lpWord    data;
   } lpBusWrite;

endpackage

`default_nettype wire

// File: src/lpFormsPkg.sv
// Character code, line and page count types and forms constants for the LP20 forms logic

`default_nettype none

package lpFormsPkg;

   //////////////////////////////////////////////////
   // Forms types
   //////////////////////////////////////////////////

   // Printer character code
   typedef logic [7:0] lpChar;

   // Line position within the form
   typedef logic [6:0] lpLineCount;

   // Page count held in PCTR
   typedef logic [11:0] lpPageCount;

   // PCTR field width as seen on the bus
   localparam int pctrWidth = 16;

   //////////////////////////////////////////////////
   // Control codes and form size
   //////////////////////////////////////////////////

   // Advance one line
   localparam lpChar charLineFeed = 8'h0A;

   // Skip to top of next form
   localparam lpChar charFormFeed = 8'h0C;

   // Lines per form
   localparam lpLineCount formLength = 7'd66;

   // Character strobe from the print data path
   typedef struct packed {
      logic  valid;
      lpChar code;
   } lpCharIn;

endpackage

`default_nettype wire

// File: src/lpPageCounter.sv
// Page count register with load, decrement, test mode step and page-zero detect

`default_nettype none
`timescale 1ns/1ps

module lpPageCounter (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   init,
   input  wire logic                   pctrWrite,
   input  wire lpFormsPkg::lpPageCount loadValue,
   input  wire logic                   testPctr,
   input  wire logic                   csrbStep,
   input  wire logic                   topOfForm,
   output logic                        setPageZero,
   output lpFormsPkg::lpPageCount      pctrValue
);

   import lpFormsPkg::*;

   //////////////////////////////////////////////////
   // Decrement request
   //////////////////////////////////////////////////

   logic decrement;
   lpPageCount count;

   // Test mode steps from CSRB writes only
   // Normal mode steps on each top of form
   assign decrement = testPctr ? csrbStep : topOfForm;

   //////////////////////////////////////////////////
   // Count register
   //////////////////////////////////////////////////

   // Clear wins over load, load wins over decrement
   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         count <= '0;
      end
      else if (pctrWrite)
      begin
         count <= loadValue;
      end
      else if (decrement)
      begin
         // Wraps from 0 to all ones
         count <= count - lpPageCount'(1);
      end
   end

   //////////////////////////////////////////////////
   // Page zero detect
   //////////////////////////////////////////////////

   // About to step from 1 to 0
   assign setPageZero = decrement && (count == lpPageCount'(1));

   assign pctrValue = count;

endmodule

`default_nettype wire

// File: src/lpFormControl.sv
// Line feed and form feed tracking, line position and registered top-of-form pulse

`default_nettype none
`timescale 1ns/1ps

module lpFormControl (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   init,
   input  wire lpFormsPkg::lpCharIn    charIn,
   output logic                        topOfForm,
   output lpFormsPkg::lpLineCount      linePos
);

   import lpFormsPkg::*;

   //////////////////////////////////////////////////
   // Character decode
   //////////////////////////////////////////////////

   logic isLineFeed;
   logic isFormFeed;
   logic lastLine;
   lpLineCount lineNext;
   logic tofNext;

   // Only strobed codes count
   assign isLineFeed = charIn.valid && (charIn.code == charLineFeed);
   assign isFormFeed = charIn.valid && (charIn.code == charFormFeed);

   // Next line feed fills the form
   assign lastLine = (linePos == formLength - lpLineCount'(1));

   //////////////////////////////////////////////////
   // Next line position and pulse
   //////////////////////////////////////////////////

   always_comb
   begin
      lineNext = linePos;
      tofNext  = 1'b0;

      if (isFormFeed)
      begin
         // Skip to top of next form
         lineNext = '0;
         tofNext  = 1'b1;
      end
      else if (isLineFeed)
      begin
         if (lastLine)
         begin
            // Form full, wrap
            lineNext = '0;
            tofNext  = 1'b1;
         end
         else
         begin
            lineNext = linePos + lpLineCount'(1);
         end
      end
      // Other codes leave the position alone
   end

   //////////////////////////////////////////////////
   // State registers
   //////////////////////////////////////////////////

   // Init also drops a pulse from the same cycle
   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         linePos   <= '0;
         topOfForm <= 1'b0;
      end
      else
      begin
         linePos   <= lineNext;
         // One cycle wide, one per feed
         topOfForm <= tofNext;
      end
   end

endmodule

`default_nettype wire

// File: src/lpRegisters.sv
// Bus write decode, CSRA and CSRB storage, sticky page-zero flag, interrupt and read mux

`default_nettype none
`timescale 1ns/1ps

module lpRegisters (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire lpRegsPkg::lpBusWrite   busWr,
   input  wire lpRegsPkg::lpRegAddr    busReadAddr,
   output lpRegsPkg::lpWord            busReadData,
   output logic                        initPulse,
   output logic                        testPctr,
   output logic                        csrbStep,
   output logic                        pctrWrite,
   output lpFormsPkg::lpPageCount      loadValue,
   input  wire logic                   setPageZero,
   input  wire lpFormsPkg::lpPageCount pctrValue,
   input  wire lpFormsPkg::lpLineCount linePos,
   output logic                        irq
);

   import lpRegsPkg::*;
   import lpFormsPkg::*;

   //////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////

   logic csraWrite;
   logic csrbWrite;
   logic intEnable;
   logic pageZero;
   lpCsrb csrb;
   lpWord readData;

   assign csraWrite = busWr.wr && (busWr.addr == addrCsra);
   assign csrbWrite = busWr.wr && (busWr.addr == addrCsrb);
   assign pctrWrite = busWr.wr && (busWr.addr == addrPctr);

   // Init is a pulse only, nothing stores it
   assign initPulse = csraWrite && busWr.data[csraInit];

   // Page counter gates this with test mode
   assign csrbStep  = csrbWrite && busWr.data[csrbTestStep];

   // Low bits of the write carry the new page count
   assign loadValue = lpPageCount'(busWr.data);

   //////////////////////////////////////////////////
   // CSRA control bits
   //////////////////////////////////////////////////

   // Init leaves these alone, each CSRA write reloads them
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         intEnable <= 1'b0;
         testPctr  <= 1'b0;
      end
      else if (csraWrite)
      begin
         intEnable <= busWr.data[csraIntEnable];
         testPctr  <= busWr.data[csraTestPctr];
      end
   end

   // Sticky page zero
   // A set in the same cycle beats the clear
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pageZero <= 1'b0;
      end
      else if (setPageZero)
      begin
         pageZero <= 1'b1;
      end
      else if (csraWrite && busWr.data[csraPageZero])
      begin
         pageZero <= 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // CSRB diagnostic byte
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csrb <= '0;
      end
      else if (csrbWrite)
      begin
         csrb <= lpCsrb'(busWr.data);
      end
   end

   // Interrupt
   assign irq = pageZero && intEnable;

   //////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////

   always_comb
   begin
      readData = '0;
      case (busReadAddr)
         addrCsra:
         begin
            readData[csraIntEnable] = intEnable;
            readData[csraPageZero]  = pageZero;
            readData[csraTestPctr]  = testPctr;
         end
         addrCsrb:
         begin
            readData = lpWord'(csrb);
         end
         addrPctr:
         begin
            // Count sits in a wider field, top bits zero
            readData[pctrWidth-1:0] = pctrWidth'(pctrValue);
         end
         addrLine:
         begin
            readData = lpWord'(linePos);
         end
         default:
         begin
            readData = '0;
         end
      endcase
   end

   assign busReadData = readData;

endmodule

`default_nettype wire

// File: src/lp20.sv
// LP20 top level joining bus registers, forms control and page counter

`default_nettype none
`timescale 1ns/1ps

module lp20 (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire lpRegsPkg::lpBusWrite busWr,
   input  wire lpRegsPkg::lpRegAddr  busReadAddr,
   output lpRegsPkg::lpWord          busReadData,
   input  wire lpFormsPkg::lpCharIn  charIn,
   output logic                      irq
);

   import lpFormsPkg::*;

   //////////////////////////////////////////////////
   // Internal wires
   //////////////////////////////////////////////////

   logic initPulse;
   logic testPctr;
   logic csrbStep;
   logic pctrWrite;
   logic setPageZero;
   logic topOfForm;
   lpPageCount loadValue;
   lpPageCount pctrValue;
   lpLineCount linePos;

   // Host side registers
   lpRegisters regs (
      .clk         (clk),
      .reset       (reset),
      .busWr       (busWr),
      .busReadAddr (busReadAddr),
      .busReadData (busReadData),
      .initPulse   (initPulse),
      .testPctr    (testPctr),
      .csrbStep    (csrbStep),
      .pctrWrite   (pctrWrite),
      .loadValue   (loadValue),
      .setPageZero (setPageZero),
      .pctrValue   (pctrValue),
      .linePos     (linePos),
      .irq         (irq)
   );

   // Line tracking from the character stream
   lpFormControl forms (
      .clk       (clk),
      .reset     (reset),
      .init      (initPulse),
      .charIn    (charIn),
      .topOfForm (topOfForm),
      .linePos   (linePos)
   );

   // Pages left
   lpPageCounter pctr (
      .clk         (clk),
      .reset       (reset),
      .init        (initPulse),
      .pctrWrite   (pctrWrite),
      .loadValue   (loadValue),
      .testPctr    (testPctr),
      .csrbStep    (csrbStep),
      .topOfForm   (topOfForm),
      .setPageZero (setPageZero),
      .pctrValue   (pctrValue)
   );

endmodule

`default_nettype wire

// File: dv/lpPageCounter_asserts.sv
// Concurrent assertions on page counter request, page-zero underflow and test mode

`default_nettype none
`timescale 1ns/1ps

module lpPageCounter_asserts (
   input wire logic                   clk,
   input wire logic                   reset,
   input wire logic                   init,
   input wire logic                   pctrWrite,
   input wire logic                   testPctr,
   input wire logic                   csrbStep,
   input wire logic                   topOfForm,
   input wire logic                   setPageZero,
   input wire lpFormsPkg::lpPageCount pctrValue
);

   int failCount = 0;
   logic request;

   // Decrement request as seen from the ports
   assign request = testPctr ? csrbStep : topOfForm;

   //////////////////////////////////////////////////
   // Properties
   //////////////////////////////////////////////////

   // Page zero only with a request
   pageZeroNeedsRequest: assert property (@(posedge clk) disable iff (reset)
      setPageZero |-> request)
   else
   begin
      $error("page zero detect fired without a decrement request");
      failCount++;
   end

   // Count lands on zero, no wrap past it
   pageZeroLandsOnZero: assert property (@(posedge clk) disable iff (reset)
      (setPageZero && !init && !pctrWrite) |=> (pctrValue == '0))
   else
   begin
      $error("count did not stop at zero after page zero detect");
      failCount++;
   end

   // Test mode ignores top of form
   testModeHoldsCount: assert property (@(posedge clk) disable iff (reset)
      (testPctr && topOfForm && !csrbStep && !init && !pctrWrite) |=> $stable(pctrValue))
   else
   begin
      $error("count moved on top of form while in test mode");
      failCount++;
   end

endmodule

`default_nettype wire

// File: dv/lp20Tb.sv
// LP20 testbench with clock, reset, xorshift stimulus, cycle model, compare tasks and watchdog

`default_nettype none
`timescale 1ns/1ps

module lp20Tb;

   import lpRegsPkg::*;
   import lpFormsPkg::*;

   localparam int clkPeriod    = 40;
   localparam int numCycles    = 2000;
   // Run length plus reset and a margin
   localparam int watchdogTime = (numCycles + 10) * clkPeriod + 2000;

   logic clk;
   logic reset;
   lpBusWrite busWr;
   lpRegAddr busReadAddr;
   lpWord busReadData;
   lpCharIn charIn;
   logic irq;

   // Cycle model state
   lpPageCount mCount;
   lpLineCount mLine;
   logic mTof;
   logic mIntEnable;
   logic mTestPctr;
   logic mPageZero;
   lpCsrb mCsrb;

   logic [31:0] rngState;
   int errorCount;
   int checkCount;
   int assertFails;

   lp20 uut (
      .clk         (clk),
      .reset       (reset),
      .busWr       (busWr),
      .busReadAddr (busReadAddr),
      .busReadData (busReadData),
      .charIn      (charIn),
      .irq         (irq)
   );

   bind lpPageCounter lpPageCounter_asserts pctrChecks (
      .clk         (clk),
      .reset       (reset),
      .init        (init),
      .pctrWrite   (pctrWrite),
      .testPctr    (testPctr),
      .csrbStep    (csrbStep),
      .topOfForm   (topOfForm),
      .setPageZero (setPageZero),
      .pctrValue   (pctrValue)
   );

   always #(clkPeriod / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // Random numbers
   //////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] nextRandom();
      rngState = xorshift(rngState);
      return rngState;
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic compareWord(input string name, input lpWord got, input lpWord exp);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("Error %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic expectIrq(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("Error %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic verifyLine(input string name, input lpLineCount got, input lpLineCount exp);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("Error %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Register view of the model state
   function automatic lpWord expectedRead(input lpRegAddr a);
      lpWord w;
      w = '0;
      if (a == addrCsra)
      begin
         w[csraIntEnable] = mIntEnable;
         w[csraPageZero]  = mPageZero;
         w[csraTestPctr]  = mTestPctr;
      end
      else if (a == addrCsrb)
      begin
         w[7:0] = mCsrb;
      end
      else if (a == addrPctr)
      begin
         // Bits 15 to 12 stay zero
         w[11:0] = mCount;
      end
      else
      begin
         w[6:0] = mLine;
      end
      return w;
   endfunction

   // One clock edge with the inputs now on the pins
   task automatic stepModel();
      logic csraWr;
      logic csrbWr;
      logic pctrWr;
      logic initWr;
      logic step;
      logic dec;
      logic lf;
      logic ff;
      csraWr = busWr.wr && (busWr.addr == addrCsra);
      csrbWr = busWr.wr && (busWr.addr == addrCsrb);
      pctrWr = busWr.wr && (busWr.addr == addrPctr);
      initWr = csraWr && busWr.data[csraInit];
      step   = csrbWr && busWr.data[csrbTestStep];
      // Old mode and old pulse decide the request
      dec    = mTestPctr ? step : mTof;
      lf     = charIn.valid && (charIn.code == charLineFeed);
      ff     = charIn.valid && (charIn.code == charFormFeed);

      // Set beats clear
      if (dec && (mCount == 12'd1))
         mPageZero = 1'b1;
      else if (csraWr && busWr.data[csraPageZero])
         mPageZero = 1'b0;

      if (initWr)
         mCount = '0;
      else if (pctrWr)
         mCount = busWr.data[11:0];
      else if (dec)
         mCount = mCount - 12'd1;

      // Init also swallows a feed in the same cycle
      if (initWr)
      begin
         mLine = '0;
         mTof  = 1'b0;
      end
      else if (ff || (lf && (mLine == formLength - 7'd1)))
      begin
         mLine = '0;
         mTof  = 1'b1;
      end
      else
      begin
         if (lf)
            mLine = mLine + 7'd1;
         mTof = 1'b0;
      end

      if (csraWr)
      begin
         mIntEnable = busWr.data[csraIntEnable];
         mTestPctr  = busWr.data[csraTestPctr];
      end
      if (csrbWr)
         mCsrb = busWr.data[7:0];
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic driveInputs();
      logic [31:0] r;
      logic [31:0] d;
      logic [5:0] op;
      logic [5:0] sel;
      lpBusWrite w;
      lpCharIn c;
      r   = nextRandom();
      d   = nextRandom();
      op  = r[7:2];
      sel = r[15:10];
      w   = '0;
      w.data = {d[3:0], d};

      // Mostly idle bus, CSRB writes most common
      if (op < 6'd2)
      begin
         w.wr   = 1'b1;
         w.addr = addrCsra;
         w.data[csraInit]      = (r[26:24] == 3'd0);
         w.data[csraIntEnable] = r[27] | r[28];
         w.data[csraPageZero]  = r[29];
         w.data[csraTestPctr]  = r[30];
      end
      else if (op < 6'd5)
      begin
         w.wr   = 1'b1;
         w.addr = addrCsrb;
      end
      else if (op == 6'd5)
      begin
         w.wr   = 1'b1;
         w.addr = addrPctr;
         // Small page counts, junk above the field
         w.data[11:0] = {9'd0, r[26:24]};
      end
      else if (op == 6'd6)
      begin
         // Read-only register
         w.wr   = 1'b1;
         w.addr = addrLine;
      end

      // Three strobes in four, mostly line feeds
      c.valid = (r[9:8] != 2'd0);
      if (sel == 6'd0)
         c.code = charFormFeed;
      else if (sel < 6'd48)
         c.code = charLineFeed;
      else
         c.code = r[23:16];

      busWr       = w;
      charIn      = c;
      busReadAddr = r[1:0];
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      int i;
      clk         = 1'b0;
      reset       = 1'b1;
      busWr       = '0;
      busReadAddr = '0;
      charIn      = '0;
      rngState    = 32'd15;
      errorCount  = 0;
      checkCount  = 0;
      mCount      = '0;
      mLine       = '0;
      mTof        = 1'b0;
      mIntEnable  = 1'b0;
      mTestPctr   = 1'b0;
      mPageZero   = 1'b0;
      mCsrb       = '0;

      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (i = 0; i < numCycles; i++)
      begin
         @(negedge clk);
         // Outputs settled since the rising edge
         compareWord("busReadData", busReadData, expectedRead(busReadAddr));
         expectIrq("irq", irq, mPageZero && mIntEnable);
         verifyLine("linePos", uut.linePos, mLine);
         driveInputs();
         stepModel();
      end

      @(negedge clk);
      compareWord("busReadData", busReadData, expectedRead(busReadAddr));
      expectIrq("irq", irq, mPageZero && mIntEnable);
      verifyLine("linePos", uut.linePos, mLine);

      assertFails = uut.pctr.pctrChecks.failCount;
      errorCount  = errorCount + assertFails;
      $display("Checks %0d, errors %0d, assertion failures %0d",
               checkCount, errorCount, assertFails);
      if (errorCount == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(watchdogTime);
      $display("Timeout: the run did not reach its end in time");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: lp20.f
src/lpRegsPkg.sv
src/lpFormsPkg.sv
src/lpPageCounter.sv
src/lpFormControl.sv
src/lpRegisters.sv
src/lp20.sv
dv/lpPageCounter_asserts.sv
dv/lp20Tb.sv

// File: run.sh
#!/bin/sh
# Build the LP20 testbench with Verilator, run it and search the log for the pass line

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module lp20Tb -f lp20.f -o lp20Sim \
   && ./obj_dir/lp20Sim +verilator+error+limit+1000 | tee sim.log \
   && grep -qx "Test completed successfully" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation did not pass"; exit 1; }
